// ==== hdl/rv_pkg.sv ====
package rv_pkg;

    localparam int XLEN       = 32;  // Data and address width
    localparam int REG_ADDR_W = 5;   // 32 architectural registers

    // Values are the raw 7-bit opcode field so decode can cast directly
    typedef enum logic [6:0] {
        opc_illegal = 7'b0000000,
        opc_load    = 7'b0000011,
        opc_op_imm  = 7'b0010011,
        opc_auipc   = 7'b0010111,
        opc_store   = 7'b0100011,
        opc_op      = 7'b0110011,
        opc_lui     = 7'b0110111,
        opc_branch  = 7'b1100011,
        opc_jalr    = 7'b1100111,
        opc_jal     = 7'b1101111
    } opcode_e;

    // Immediate formats
    typedef enum logic [2:0] {
        fmt_r,
        fmt_i,
        fmt_s,
        fmt_b,
        fmt_u,
        fmt_j,
        fmt_none
    } inst_fmt_e;

    typedef enum logic [3:0] {
        alu_add,
        alu_sub,
        alu_sll,
        alu_slt,
        alu_sltu,
        alu_xor,
        alu_srl,
        alu_sra,
        alu_or,
        alu_and
    } alu_op_e;

    // Decoded instruction fields
    typedef struct packed {
        opcode_e                op;
        logic [2:0]             funct3;
        logic                   alt;     // funct7 bit 5
        logic [REG_ADDR_W-1:0]  rd;
        logic [REG_ADDR_W-1:0]  rs1;
        logic [REG_ADDR_W-1:0]  rs2;
        logic [XLEN-1:0]        imm;
    } decoded_t;

    // One retired instruction
    typedef struct packed {
        logic [XLEN-1:0]        pc;
        logic [XLEN-1:0]        next_pc;
        logic                   rd_we;
        logic [REG_ADDR_W-1:0]  rd;
        logic [XLEN-1:0]        rd_data;
    } retire_t;

endpackage

// ==== hdl/fetch_unit.sv ====
`timescale 1ns/1ps

module fetch_unit #(
    parameter logic [rv_pkg::XLEN-1:0] RESET_PC = '0
) (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    jump_en,
    input  logic [rv_pkg::XLEN-1:0] jump_target,
    output logic [rv_pkg::XLEN-1:0] pc,
    output logic [rv_pkg::XLEN-1:0] snpc
);

    logic [rv_pkg::XLEN-1:0] dnpc;  // Next pc after this instruction

    assign snpc = pc + rv_pkg::XLEN'(4);
    assign dnpc = jump_en ? jump_target : snpc;

    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= RESET_PC;
        end else begin
            pc <= dnpc;
        end
    end

    // Jump targets come from execute, so misalignment would show up here
    pc_word_aligned: assert property (
        @(posedge clk) disable iff (reset) pc[1:0] == 2'b00
    ) else $error("pc %h is not word aligned", pc);

endmodule

// ==== hdl/decode_unit.sv ====
`timescale 1ns/1ps

module decode_unit (
    input  logic [rv_pkg::XLEN-1:0] inst,
    output rv_pkg::decoded_t        dec
);

    rv_pkg::opcode_e         op;
    rv_pkg::inst_fmt_e       fmt;
    logic [rv_pkg::XLEN-1:0] imm;

    // Opcode classification, unknown encodings become illegal
    always_comb begin
        case (inst[6:0])
            rv_pkg::opc_load,
            rv_pkg::opc_op_imm,
            rv_pkg::opc_auipc,
            rv_pkg::opc_store,
            rv_pkg::opc_op,
            rv_pkg::opc_lui,
            rv_pkg::opc_branch,
            rv_pkg::opc_jalr,
            rv_pkg::opc_jal: op = rv_pkg::opcode_e'(inst[6:0]);
            default:         op = rv_pkg::opc_illegal;
        endcase
    end

    // Immediate format follows from the opcode
    always_comb begin
        case (op)
            rv_pkg::opc_op:     fmt = rv_pkg::fmt_r;
            rv_pkg::opc_op_imm,
            rv_pkg::opc_load,
            rv_pkg::opc_jalr:   fmt = rv_pkg::fmt_i;
            rv_pkg::opc_store:  fmt = rv_pkg::fmt_s;
            rv_pkg::opc_branch: fmt = rv_pkg::fmt_b;
            rv_pkg::opc_lui,
            rv_pkg::opc_auipc:  fmt = rv_pkg::fmt_u;
            rv_pkg::opc_jal:    fmt = rv_pkg::fmt_j;
            default:            fmt = rv_pkg::fmt_none;
        endcase
    end

    always_comb begin
        case (fmt)
            rv_pkg::fmt_i: imm = {{20{inst[31]}}, inst[31:20]};
            rv_pkg::fmt_s: imm = {{20{inst[31]}}, inst[31:25], inst[11:7]};
            rv_pkg::fmt_b: begin
                // Offset in half words, bit 0 always zero
                imm = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
            end
            rv_pkg::fmt_u: imm = {inst[31:12], 12'b0};
            rv_pkg::fmt_j: begin
                imm = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};
            end
            default:       imm = '0;  // R type and illegal
        endcase
    end

    always_comb begin
        dec.op     = op;
        dec.funct3 = inst[14:12];
        dec.alt    = inst[30];
        dec.rd     = inst[11:7];
        dec.rs1    = inst[19:15];
        dec.rs2    = inst[24:20];
        dec.imm    = imm;
    end

endmodule

// ==== hdl/reg_file.sv ====
`timescale 1ns/1ps

module reg_file (
    input  logic                          clk,
    input  logic                          reset,
    input  logic [rv_pkg::REG_ADDR_W-1:0] rs1,
    input  logic [rv_pkg::REG_ADDR_W-1:0] rs2,
    output logic [rv_pkg::XLEN-1:0]       rs1_data,
    output logic [rv_pkg::XLEN-1:0]       rs2_data,
    input  logic                          rd_we,
    input  logic [rv_pkg::REG_ADDR_W-1:0] rd,
    input  logic [rv_pkg::XLEN-1:0]       rd_data
);

    logic [rv_pkg::XLEN-1:0] regs [32];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (rd_we && rd != '0) begin  // x0 stays zero
            regs[rd] <= rd_data;
        end
    end

    // Combinational read ports
    assign rs1_data = (rs1 == '0) ? '0 : regs[rs1];
    assign rs2_data = (rs2 == '0) ? '0 : regs[rs2];

endmodule

// ==== hdl/execute_unit.sv ====
`timescale 1ns/1ps

module execute_unit (
    input  rv_pkg::decoded_t        dec,
    input  logic [rv_pkg::XLEN-1:0] pc,
    input  logic [rv_pkg::XLEN-1:0] snpc,
    input  logic [rv_pkg::XLEN-1:0] rs1_data,
    input  logic [rv_pkg::XLEN-1:0] rs2_data,
    input  logic [rv_pkg::XLEN-1:0] load_data,
    output logic [rv_pkg::XLEN-1:0] mem_addr,
    output logic                    jump_en,
    output logic [rv_pkg::XLEN-1:0] jump_target,
    output logic                    rd_we,
    output logic [rv_pkg::XLEN-1:0] rd_data
);

    rv_pkg::alu_op_e         alu_op;
    logic [rv_pkg::XLEN-1:0] alu_a;
    logic [rv_pkg::XLEN-1:0] alu_b;
    logic [rv_pkg::XLEN-1:0] alu_result;
    logic                    taken;  // Branch condition

    // Only register and immediate arithmetic use funct3, everything else adds
    always_comb begin
        alu_op = rv_pkg::alu_add;
        if (dec.op == rv_pkg::opc_op || dec.op == rv_pkg::opc_op_imm) begin
            case (dec.funct3)
                3'b000: begin
                    // Immediate form has no subtract
                    if (dec.op == rv_pkg::opc_op && dec.alt) alu_op = rv_pkg::alu_sub;
                end
                3'b001:  alu_op = rv_pkg::alu_sll;
                3'b010:  alu_op = rv_pkg::alu_slt;
                3'b011:  alu_op = rv_pkg::alu_sltu;
                3'b100:  alu_op = rv_pkg::alu_xor;
                3'b101:  alu_op = dec.alt ? rv_pkg::alu_sra : rv_pkg::alu_srl;
                3'b110:  alu_op = rv_pkg::alu_or;
                default: alu_op = rv_pkg::alu_and;
            endcase
        end
    end

    always_comb begin
        case (dec.op)
            rv_pkg::opc_lui:     alu_a = '0;
            rv_pkg::opc_auipc,
            rv_pkg::opc_jal,
            rv_pkg::opc_branch:  alu_a = pc;  // pc relative
            default:             alu_a = rs1_data;
        endcase
        alu_b = (dec.op == rv_pkg::opc_op) ? rs2_data : dec.imm;
    end

    always_comb begin
        case (alu_op)
            rv_pkg::alu_sub:  alu_result = alu_a - alu_b;
            rv_pkg::alu_sll:  alu_result = alu_a << alu_b[4:0];
            rv_pkg::alu_slt:  alu_result = {31'b0, $signed(alu_a) < $signed(alu_b)};
            rv_pkg::alu_sltu: alu_result = {31'b0, alu_a < alu_b};
            rv_pkg::alu_xor:  alu_result = alu_a ^ alu_b;
            rv_pkg::alu_srl:  alu_result = alu_a >> alu_b[4:0];
            rv_pkg::alu_sra:  alu_result = $signed(alu_a) >>> alu_b[4:0];
            rv_pkg::alu_or:   alu_result = alu_a | alu_b;
            rv_pkg::alu_and:  alu_result = alu_a & alu_b;
            default:          alu_result = alu_a + alu_b;
        endcase
    end

    // Branch compare on the register operands
    always_comb begin
        case (dec.funct3)
            3'b000:  taken = rs1_data == rs2_data;
            3'b001:  taken = rs1_data != rs2_data;
            3'b100:  taken = $signed(rs1_data) < $signed(rs2_data);
            3'b101:  taken = $signed(rs1_data) >= $signed(rs2_data);
            3'b110:  taken = rs1_data < rs2_data;
            3'b111:  taken = rs1_data >= rs2_data;
            default: taken = 1'b0;
        endcase
    end

    always_comb begin
        jump_en     = 1'b0;
        jump_target = alu_result;
        case (dec.op)
            rv_pkg::opc_jal:    jump_en = 1'b1;
            rv_pkg::opc_jalr: begin
                jump_en     = 1'b1;
                jump_target = {alu_result[rv_pkg::XLEN-1:1], 1'b0};
            end
            rv_pkg::opc_branch: jump_en = taken;
            default:            jump_en = 1'b0;
        endcase
    end

    always_comb begin
        case (dec.op)
            rv_pkg::opc_op,
            rv_pkg::opc_op_imm,
            rv_pkg::opc_load,
            rv_pkg::opc_lui,
            rv_pkg::opc_auipc,
            rv_pkg::opc_jal,
            rv_pkg::opc_jalr: rd_we = 1'b1;
            default:          rd_we = 1'b0;  // Stores, branches, illegal
        endcase
    end

    always_comb begin
        if (dec.op == rv_pkg::opc_load) begin
            rd_data = load_data;
        end else if (dec.op == rv_pkg::opc_jal || dec.op == rv_pkg::opc_jalr) begin
            rd_data = snpc;  // Link address
        end else begin
            rd_data = alu_result;
        end
    end

    assign mem_addr = alu_result;  // rs1 + imm for loads and stores

endmodule

// ==== hdl/data_mem.sv ====
`timescale 1ns/1ps

module data_mem #(
    parameter int DMEM_WORDS = 256
) (
    input  logic                    clk,
    input  logic                    reset,
    input  rv_pkg::decoded_t        dec,
    input  logic [rv_pkg::XLEN-1:0] addr,
    input  logic [rv_pkg::XLEN-1:0] store_data,
    output logic [rv_pkg::XLEN-1:0] load_data
);

    localparam int IDX_W = $clog2(DMEM_WORDS);

    logic [3:0][7:0]         mem [DMEM_WORDS];  // Four byte lanes per word
    logic                    is_load;
    logic                    is_store;
    logic [IDX_W-1:0]        word_idx;
    logic [3:0]              byte_en;
    logic [3:0][7:0]         store_lanes;
    logic [rv_pkg::XLEN-1:0] load_word;
    logic [rv_pkg::XLEN-1:0] load_shifted;

    assign is_load  = dec.op == rv_pkg::opc_load;
    assign is_store = dec.op == rv_pkg::opc_store;
    assign word_idx = addr[IDX_W+1:2];  // Wraps modulo memory size

    // funct3[1:0] gives the access size
    always_comb begin
        case (dec.funct3[1:0])
            2'b00:   byte_en = 4'b0001 << addr[1:0];
            2'b01:   byte_en = 4'b0011 << addr[1:0];
            default: byte_en = 4'b1111;
        endcase
    end

    assign store_lanes = store_data << {addr[1:0], 3'b000};  // Move data onto its lanes

    always_ff @(posedge clk) begin
        if (!reset && is_store) begin
            for (int b = 0; b < 4; b++) begin
                if (byte_en[b]) mem[word_idx][b] <= store_lanes[b];
            end
        end
    end

    assign load_word    = mem[word_idx];
    assign load_shifted = load_word >> {addr[1:0], 3'b000};

    always_comb begin
        case (dec.funct3)
            3'b000:  load_data = {{24{load_shifted[7]}}, load_shifted[7:0]};    // lb
            3'b001:  load_data = {{16{load_shifted[15]}}, load_shifted[15:0]};  // lh
            3'b100:  load_data = {24'b0, load_shifted[7:0]};                    // lbu
            3'b101:  load_data = {16'b0, load_shifted[15:0]};                   // lhu
            default: load_data = load_word;
        endcase
    end

    // Address comes from the execute adder, size from decode
    half_aligned: assert property (
        @(posedge clk) disable iff (reset)
        ((is_load || is_store) && dec.funct3[1:0] == 2'b01) |-> addr[0] == 1'b0
    ) else $error("misaligned half access at %h", addr);

    word_aligned: assert property (
        @(posedge clk) disable iff (reset)
        ((is_load || is_store) && dec.funct3[1:0] == 2'b10) |-> addr[1:0] == 2'b00
    ) else $error("misaligned word access at %h", addr);

endmodule

// ==== hdl/rv_core.sv ====
`timescale 1ns/1ps

module rv_core #(
    parameter logic [rv_pkg::XLEN-1:0] RESET_PC   = '0,
    parameter int                      DMEM_WORDS = 256
) (
    input  logic                    clk,
    input  logic                    reset,
    input  logic [rv_pkg::XLEN-1:0] inst,
    output logic [rv_pkg::XLEN-1:0] pc,
    output rv_pkg::retire_t         retire
);

    logic [rv_pkg::XLEN-1:0] snpc;
    logic                    jump_en;
    logic [rv_pkg::XLEN-1:0] jump_target;
    rv_pkg::decoded_t        dec;
    logic [rv_pkg::XLEN-1:0] rs1_data;
    logic [rv_pkg::XLEN-1:0] rs2_data;
    logic                    rd_we;
    logic [rv_pkg::XLEN-1:0] rd_data;
    logic [rv_pkg::XLEN-1:0] mem_addr;
    logic [rv_pkg::XLEN-1:0] load_data;

    fetch_unit #(.RESET_PC(RESET_PC)) u_fetch (
        .clk(clk), .reset(reset),
        .jump_en(jump_en), .jump_target(jump_target),
        .pc(pc), .snpc(snpc)
    );

    decode_unit u_decode (.inst(inst), .dec(dec));

    reg_file u_regs (
        .clk(clk), .reset(reset),
        .rs1(dec.rs1), .rs2(dec.rs2),
        .rs1_data(rs1_data), .rs2_data(rs2_data),
        .rd_we(rd_we), .rd(dec.rd), .rd_data(rd_data)
    );

    execute_unit u_execute (
        .dec(dec), .pc(pc), .snpc(snpc),
        .rs1_data(rs1_data), .rs2_data(rs2_data), .load_data(load_data),
        .mem_addr(mem_addr), .jump_en(jump_en), .jump_target(jump_target),
        .rd_we(rd_we), .rd_data(rd_data)
    );

    data_mem #(.DMEM_WORDS(DMEM_WORDS)) u_dmem (
        .clk(clk), .reset(reset), .dec(dec),
        .addr(mem_addr), .store_data(rs2_data),  // Store data is always rs2
        .load_data(load_data)
    );

    // Retire view of the instruction at pc in this cycle
    assign retire.pc      = pc;
    assign retire.next_pc = jump_en ? jump_target : snpc;
    assign retire.rd_we   = rd_we && !reset;  // Nothing retires a write during reset
    assign retire.rd      = dec.rd;
    assign retire.rd_data = rd_data;

endmodule

// ==== test/tb_programs.svh ====
`ifndef TB_PROGRAMS_SVH
`define TB_PROGRAMS_SVH

logic [31:0] prog [$];  // Instruction words, index is pc/4

function automatic logic [31:0] enc_r(logic [6:0] f7, logic [4:0] rs2, rs1,
                                      logic [2:0] f3, logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, 7'b0110011};
endfunction

function automatic logic [31:0] enc_i(logic [11:0] imm, logic [4:0] rs1, logic [2:0] f3,
                                      logic [4:0] rd, logic [6:0] opc);
    return {imm, rs1, f3, rd, opc};
endfunction

function automatic logic [31:0] enc_s(logic [11:0] imm, logic [4:0] rs2, rs1, logic [2:0] f3);
    return {imm[11:5], rs2, rs1, f3, imm[4:0], 7'b0100011};
endfunction

function automatic logic [31:0] enc_b(logic [12:0] imm, logic [4:0] rs2, rs1, logic [2:0] f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
endfunction

function automatic logic [31:0] enc_u(logic [19:0] imm, logic [4:0] rd, logic [6:0] opc);
    return {imm, rd, opc};
endfunction

function automatic logic [31:0] enc_j(logic [20:0] imm, logic [4:0] rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
endfunction

// The extra 0x800 undoes the sign extension of the low part
task automatic load_const(logic [4:0] rd, logic [31:0] value);
    logic [31:0] upper;
    upper = value + 32'h800;
    prog.push_back(enc_u(upper[31:12], rd, rv_pkg::opc_lui));
    prog.push_back(enc_i(value[11:0], rd, 3'b000, rd, rv_pkg::opc_op_imm));
endtask

task automatic build_alu();
    logic [11:0] imm;
    for (int rep = 0; rep < 2; rep++) begin
        for (int k = 0; k < 8; k++) begin
            load_const(5'd1, $urandom());
            load_const(5'd2, $urandom());
            imm = (k == 1 || k == 5) ? {7'h00, 5'($urandom())} : 12'($urandom());
            prog.push_back(enc_r(7'h00, 5'd2, 5'd1, 3'(k), 5'd3));
            prog.push_back(enc_i(imm, 5'd1, 3'(k), 5'd4, rv_pkg::opc_op_imm));
            if (k == 0 || k == 5) begin
                prog.push_back(enc_r(7'h20, 5'd2, 5'd1, 3'(k), 5'd5));  // sub or sra
            end
            if (k == 5) begin
                prog.push_back(enc_i(imm | 12'h400, 5'd1, 3'(k), 5'd6, rv_pkg::opc_op_imm));
            end
        end
    end
endtask

task automatic build_mem();
    for (int rep = 0; rep < 4; rep++) begin
        load_const(5'd1, ($urandom() % 200) * 4);  // Word aligned base
        load_const(5'd2, $urandom());
        prog.push_back(enc_s(12'd0, 5'd2, 5'd1, 3'b010));  // sw
        load_const(5'd2, $urandom());
        prog.push_back(enc_s(12'd1, 5'd2, 5'd1, 3'b000));  // sb into lane 1
        prog.push_back(enc_s(12'd2, 5'd2, 5'd1, 3'b001));  // sh into lanes 2 and 3
        // Every load size at every offset aligned to it
        for (int f = 0; f < 6; f++) begin
            for (int off = 0; off < 4; off++) begin
                if (f != 3 && off % (1 << (f % 4)) == 0) begin
                    prog.push_back(enc_i(12'(off), 5'd1, 3'(f), 5'(off + 8), rv_pkg::opc_load));
                end
            end
        end
    end
endtask

task automatic build_branch();
    for (int k = 0; k < 8; k++) begin
        if (k == 2 || k == 3) continue;
        load_const(5'd1, $urandom());
        prog.push_back(enc_i(12'd0, 5'd1, 3'b000, 5'd2, rv_pkg::opc_op_imm));  // Equal pair
        for (int n = 0; n < 3; n++) begin
            if (n == 1) load_const(5'd2, $urandom());
            prog.push_back(enc_b(13'd8, n == 2 ? 5'd1 : 5'd2, n == 2 ? 5'd2 : 5'd1, 3'(k)));
            prog.push_back(enc_i(12'd1, 5'd7, 3'b000, 5'd7, rv_pkg::opc_op_imm));  // Skipped if taken
        end
    end
endtask

task automatic build_jump();
    prog.push_back(enc_j(21'd8, 5'd10));
    prog.push_back(enc_i(12'd1, 5'd0, 3'b000, 5'd11, rv_pkg::opc_op_imm));
    prog.push_back(enc_u(20'd0, 5'd5, rv_pkg::opc_auipc));
    prog.push_back(enc_i(12'd13, 5'd5, 3'b000, 5'd6, rv_pkg::opc_jalr));  // Odd target
    prog.push_back(enc_i(12'd1, 5'd0, 3'b000, 5'd11, rv_pkg::opc_op_imm));
    prog.push_back(enc_u(20'($urandom()), 5'd8, rv_pkg::opc_lui));
    prog.push_back(enc_u(20'($urandom()), 5'd9, rv_pkg::opc_auipc));
endtask

task automatic build_x0();
    load_const(5'd1, $urandom());
    prog.push_back(enc_i(12'($urandom()), 5'd1, 3'b000, 5'd0, rv_pkg::opc_op_imm));
    prog.push_back(enc_u(20'($urandom()), 5'd0, rv_pkg::opc_lui));
    prog.push_back(enc_r(7'h00, 5'd1, 5'd0, 3'b000, 5'd3));  // x3 = x0 + x1
    prog.push_back(enc_r(7'h00, 5'd0, 5'd1, 3'b000, 5'd4));  // x4 = x1 + x0
endtask

`endif

// ==== test/tb_rv_core.sv ====
`timescale 1ns/1ps

module tb_rv_core;

    localparam logic [31:0] RESET_PC   = 32'h0;
    localparam int          DMEM_WORDS = 256;
    localparam int          MEM_BYTES  = DMEM_WORDS * 4;
    localparam int          NUM_TESTS  = 6;

    logic            clk;
    logic            reset;
    logic [31:0]     inst;
    logic [31:0]     pc;
    rv_pkg::retire_t retire;
    rv_pkg::retire_t act_ret;  // rd fields zeroed when nothing is written
    rv_pkg::retire_t exp_ret;
    logic [31:0]     model_pc;          // Reference pc, follows the predicted next pc
    logic [31:0]     sreg [32];         // Shadow register file
    logic [7:0]      smem [MEM_BYTES];  // Shadow data memory, one entry per byte
    logic            st_en;
    logic [31:0]     st_addr;
    logic [31:0]     st_data;
    logic [1:0]      st_size;
    logic            timed_out;
    int              cycles;
    int              limit;
    int              cur_test;
    int              total;
    int              errors [NUM_TESTS];
    int              test_end [NUM_TESTS];
    string           names [NUM_TESTS] = '{"reset", "alu", "memory", "branch", "jump", "x0"};

    `include "tb_programs.svh"

    rv_core #(.RESET_PC(RESET_PC), .DMEM_WORDS(DMEM_WORDS)) dut (
        .clk(clk), .reset(reset), .inst(inst), .pc(pc), .retire(retire)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    function automatic logic [31:0] alu(logic [2:0] f3, logic alt, logic [31:0] a, b);
        case (f3)
            3'b000:  return alt ? a - b : a + b;
            3'b001:  return a << b[4:0];
            3'b010:  return {31'b0, $signed(a) < $signed(b)};
            3'b011:  return {31'b0, a < b};
            3'b100:  return a ^ b;
            3'b101: begin
                if (alt) return $signed(a) >>> b[4:0];
                return a >> b[4:0];
            end
            3'b110:  return a | b;
            default: return a & b;
        endcase
    endfunction

    function automatic logic [31:0] extend(logic [31:0] w, logic [2:0] f3);
        case (f3)
            3'b000:  return {{24{w[7]}}, w[7:0]};
            3'b001:  return {{16{w[15]}}, w[15:0]};
            3'b100:  return {24'b0, w[7:0]};
            3'b101:  return {16'b0, w[15:0]};
            default: return w;
        endcase
    endfunction

    function automatic int byte_idx(logic [31:0] a);
        return int'(a) & (MEM_BYTES - 1);  // Wraps like the data memory
    endfunction

    task automatic set_write(logic [4:0] rd, logic [31:0] data);
        exp_ret.rd_we   = 1'b1;
        exp_ret.rd      = rd;
        exp_ret.rd_data = data;
    endtask

    // Expected retire and store for instruction i at pc p
    task automatic predict(logic [31:0] i, logic [31:0] p);
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] imm_i;
        logic [31:0] ea;
        logic [31:0] w;
        logic [2:0]  f3;
        logic        take;
        a     = sreg[i[19:15]];
        b     = sreg[i[24:20]];
        f3    = i[14:12];
        imm_i = {{20{i[31]}}, i[31:20]};
        ea    = a + imm_i;
        w     = {smem[byte_idx(ea + 3)], smem[byte_idx(ea + 2)],
                 smem[byte_idx(ea + 1)], smem[byte_idx(ea)]};
        exp_ret         = '0;
        exp_ret.pc      = p;
        exp_ret.next_pc = p + 32'd4;
        st_en   = 1'b0;
        st_addr = a + {{20{i[31]}}, i[31:25], i[11:7]};
        st_data = b;
        st_size = f3[1:0];
        case (f3)
            3'b000:  take = a == b;
            3'b001:  take = a != b;
            3'b100:  take = $signed(a) < $signed(b);
            3'b101:  take = $signed(a) >= $signed(b);
            3'b110:  take = a < b;
            3'b111:  take = a >= b;
            default: take = 1'b0;
        endcase
        case (i[6:0])
            rv_pkg::opc_op:     set_write(i[11:7], alu(f3, i[30], a, b));
            rv_pkg::opc_op_imm: set_write(i[11:7], alu(f3, f3 == 3'b101 && i[30], a, imm_i));
            rv_pkg::opc_lui:    set_write(i[11:7], {i[31:12], 12'b0});
            rv_pkg::opc_auipc:  set_write(i[11:7], p + {i[31:12], 12'b0});
            rv_pkg::opc_jal: begin
                set_write(i[11:7], p + 32'd4);
                exp_ret.next_pc = p + {{12{i[31]}}, i[19:12], i[20], i[30:21], 1'b0};
            end
            rv_pkg::opc_jalr: begin
                set_write(i[11:7], p + 32'd4);
                exp_ret.next_pc = ea & ~32'd1;
            end
            rv_pkg::opc_branch: begin
                if (take) exp_ret.next_pc = p + {{20{i[31]}}, i[7], i[30:25], i[11:8], 1'b0};
            end
            rv_pkg::opc_load:   set_write(i[11:7], extend(w, f3));
            rv_pkg::opc_store:  st_en = 1'b1;
            default: ;  // Unsupported opcode just falls through
        endcase
    endtask

    always @(negedge clk) begin
        inst = (int'(pc >> 2) < prog.size()) ? prog[pc >> 2] : 32'h00000013;
        predict(inst, model_pc);
    end

    // Shadow state follows the DUT at the rising edge
    always @(posedge clk) begin
        if (reset) begin
            model_pc = RESET_PC;
        end else begin
            cycles   = cycles + 1;
            model_pc = exp_ret.next_pc;
            if (exp_ret.rd_we && exp_ret.rd != 5'd0) sreg[exp_ret.rd] = exp_ret.rd_data;
            for (int k = 0; k < 4; k++) begin
                if (st_en && k < (1 << st_size)) begin
                    smem[byte_idx(st_addr + 32'(k))] = st_data[8*k +: 8];
                end
            end
        end
    end

    always_comb begin
        act_ret = retire;
        if (!retire.rd_we) begin
            act_ret.rd      = '0;
            act_ret.rd_data = '0;
        end
    end

    retire_check: assert property (@(posedge clk) disable iff (reset) act_ret == exp_ret)
        else begin
            errors[cur_test]++;
            $display("error %s pc %h expected %h actual %h", names[cur_test],
                     $sampled(pc), $sampled(exp_ret), $sampled(act_ret));
        end

    quiet_in_reset: assert property (@(posedge clk) reset |-> !retire.rd_we)
        else begin
            errors[0]++;
            $display("reset: a register write retired while reset was high");
        end

    pc_after_reset: assert property (@(posedge clk) $fell(reset) |-> pc == RESET_PC)
        else begin
            errors[0]++;
            $display("error reset expected %h actual %h", RESET_PC, $sampled(pc));
        end

    task automatic report(int t);
        $display("test %s: %0d errors", names[t], errors[t]);
    endtask

    initial begin
        reset     = 1'b1;
        inst      = 32'h00000013;  // addi x0, x0, 0
        cycles    = 0;
        cur_test  = 0;
        total     = 0;
        timed_out = 1'b0;
        st_en     = 1'b0;
        exp_ret   = '0;
        model_pc  = RESET_PC;
        for (int r = 0; r < 32; r++) sreg[r] = '0;
        void'($urandom(67));
        test_end[0] = 0;
        build_alu();
        test_end[1] = prog.size() * 4;
        build_mem();
        test_end[2] = prog.size() * 4;
        build_branch();
        test_end[3] = prog.size() * 4;
        build_jump();
        test_end[4] = prog.size() * 4;
        build_x0();
        test_end[5] = prog.size() * 4;
        limit = prog.size() + 100;

        repeat (4) @(posedge clk);
        @(negedge clk);
        reset    = 1'b0;
        cur_test = 1;
        @(negedge clk);
        report(0);
        for (int t = 1; t < NUM_TESTS; t++) begin
            cur_test = t;
            while (pc < test_end[t] && cycles < limit) @(negedge clk);
            if (cycles >= limit) begin
                $display("timeout: pc %h never reached the end of test %s within %0d cycles",
                         pc, names[t], limit);
                timed_out = 1'b1;
                break;
            end
            report(t);
        end
        for (int t = 0; t < NUM_TESTS; t++) total += errors[t];
        $display("%0d tests, %0d errors in total", NUM_TESTS, total);
        if (total == 0 && !timed_out) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

// ==== all.f ====
+incdir+test
hdl/rv_pkg.sv
hdl/fetch_unit.sv
hdl/decode_unit.sv
hdl/reg_file.sv
hdl/execute_unit.sv
hdl/data_mem.sv
hdl/rv_core.sv
test/tb_rv_core.sv

// ==== run.sh ====
#!/bin/sh
# Build the rv_core testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module tb_rv_core -f all.f -o sim
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

./obj_dir/sim > sim.log 2>&1
sim_status=$?
cat sim.log
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if grep -q "Regression failed" sim.log; then
    exit 1
fi
exit 0
